//--- include/cache_defs.svh
// Cache geometry and bus width macros shared by the package and the RTL
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// request and memory bus widths
`define CACHE_ADDR_W    32
`define CACHE_WORD_W    64
`define CACHE_STRB_W    8

// geometry
`define CACHE_WAYS      4
`define CACHE_SETS      16
`define CACHE_BEATS     16

// address split
`define CACHE_OFFSET_W  7
`define CACHE_INDEX_W   4
`define CACHE_TAG_W     (`CACHE_ADDR_W - `CACHE_OFFSET_W - `CACHE_INDEX_W)

`endif

//--- verilog/cache_pkg.sv
// Cache types and controller state encoding
package cache_pkg;

    `include "cache_defs.svh"

    typedef logic [`CACHE_ADDR_W-1:0] addr_t;
    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef logic [`CACHE_STRB_W-1:0] strb_t;
    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;
    typedef logic [$clog2(`CACHE_BEATS)-1:0] beat_t;

    // miss handling walks writeback, refill, replay in order
    typedef enum logic [2:0] {
        st_lookup,
        st_respond,
        st_writeback,
        st_refill,
        st_replay
    } ctrl_state_t;

endpackage

//--- verilog/cache_ifs.sv
// Internal cache interfaces for tag lookup, data array ports and burst control
`timescale 1ns/1ps

// tag lookup between controller and tag store
interface lookup_if;
    import cache_pkg::*;

    index_t index;
    tag_t   tag;
    logic   write_hit;
    logic   fill;
    way_t   fill_way;
    logic   clean;
    way_t   clean_way;
    logic   hit;
    way_t   hit_way;
    way_t   victim_way;
    logic   victim_dirty;
    tag_t   victim_tag;

    modport ctrl (output index, tag, write_hit, fill, fill_way, clean, clean_way,
                  input hit, hit_way, victim_way, victim_dirty, victim_tag);
    modport store (input index, tag, write_hit, fill, fill_way, clean, clean_way,
                   output hit, hit_way, victim_way, victim_dirty, victim_tag);
endinterface

// one word port into the data array
interface data_port_if;
    import cache_pkg::*;

    way_t   way;
    index_t index;
    beat_t  beat;
    logic   rd_en;
    logic   wr_en;
    strb_t  strb;
    word_t  wdata;
    word_t  rdata;

    modport client (output way, index, beat, rd_en, wr_en, strb, wdata, input rdata);
    modport store (input way, index, beat, rd_en, wr_en, strb, wdata, output rdata);
endinterface

// line burst requests from controller to burst engine
interface burst_if;
    import cache_pkg::*;

    logic  start_read;
    logic  start_write;
    addr_t line_addr;
    way_t  way;
    logic  done;

    modport ctrl (output start_read, start_write, line_addr, way, input done);
    modport engine (input start_read, start_write, line_addr, way, output done);
endinterface

//--- verilog/tag_store.sv
// Tag store with valid, dirty and tag arrays, parallel hit compare and FIFO victim
`timescale 1ns/1ps
`include "cache_defs.svh"

module tag_store (
    input  logic    clk,
    input  logic    rst,
    lookup_if.store lk
);
    import cache_pkg::*;

    logic [`CACHE_SETS-1:0] valid_q [`CACHE_WAYS];
    logic [`CACHE_SETS-1:0] dirty_q [`CACHE_WAYS];
    tag_t                   tag_q [`CACHE_WAYS][`CACHE_SETS];
    way_t                   fifo_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] way_hit;
    way_t                   hit_way;
    way_t                   victim;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = valid_q[w][lk.index] && (tag_q[w][lk.index] == lk.tag);
        end
    end

    // lowest matching way wins
    always_comb begin
        hit_way = '0;
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign victim = fifo_q[lk.index];

    assign lk.hit          = |way_hit;
    assign lk.hit_way      = hit_way;
    assign lk.victim_way   = victim;
    assign lk.victim_dirty = dirty_q[victim][lk.index];
    assign lk.victim_tag   = tag_q[victim][lk.index];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            fifo_q  <= '{default: '0};
        end else begin
            // fill installs a clean line and moves the fifo on
            if (lk.fill) begin
                valid_q[lk.fill_way][lk.index] <= 1'b1;
                dirty_q[lk.fill_way][lk.index] <= 1'b0;
                fifo_q[lk.index]               <= fifo_q[lk.index] + 1'b1;
            end
            if (lk.clean) begin
                dirty_q[lk.clean_way][lk.index] <= 1'b0;
            end
            if (lk.write_hit) begin
                dirty_q[hit_way][lk.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lk.fill) begin
            tag_q[lk.fill_way][lk.index] <= lk.tag;
        end
    end

endmodule

//--- verilog/data_store.sv
// Cache data array of byte-writable words with a registered read port
`timescale 1ns/1ps
`include "cache_defs.svh"

module data_store (
    input  logic       clk,
    data_port_if.store ctrl_port,
    data_port_if.store burst_port
);
    import cache_pkg::*;

    localparam int addr_w = $bits(way_t) + $bits(index_t) + $bits(beat_t);

    word_t             mem_q [`CACHE_WAYS*`CACHE_SETS*`CACHE_BEATS];
    word_t             rdata_q;
    logic              sel_burst;
    logic [addr_w-1:0] word_addr;
    logic              rd_en;
    logic              wr_en;
    strb_t             strb;
    word_t             wdata;

    // burst engine owns the array while it is active
    assign sel_burst = burst_port.rd_en | burst_port.wr_en;
    assign word_addr = sel_burst ? {burst_port.way, burst_port.index, burst_port.beat} :
                                   {ctrl_port.way, ctrl_port.index, ctrl_port.beat};
    assign rd_en     = sel_burst ? burst_port.rd_en : ctrl_port.rd_en;
    assign wr_en     = sel_burst ? burst_port.wr_en : ctrl_port.wr_en;
    assign strb      = sel_burst ? burst_port.strb : ctrl_port.strb;
    assign wdata     = sel_burst ? burst_port.wdata : ctrl_port.wdata;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < `CACHE_STRB_W; b++) begin
                if (strb[b]) begin
                    mem_q[word_addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        // held until the next read
        if (rd_en) begin
            rdata_q <= mem_q[word_addr];
        end
    end

    assign ctrl_port.rdata  = rdata_q;
    assign burst_port.rdata = rdata_q;

endmodule

//--- verilog/mem_burst.sv
// Burst engine moving whole cache lines between the data array and memory
`timescale 1ns/1ps
`include "cache_defs.svh"

module mem_burst (
    input  logic             clk,
    input  logic             rst,
    burst_if.engine          bu,
    data_port_if.client      dp,
    output cache_pkg::addr_t ar_addr,
    output logic             ar_valid,
    input  logic             ar_ready,
    input  cache_pkg::word_t r_data,
    input  logic             r_valid,
    input  logic             r_last,
    output cache_pkg::addr_t aw_addr,
    output logic             aw_valid,
    input  logic             aw_ready,
    output cache_pkg::word_t w_data,
    output logic             w_valid,
    input  logic             w_ready,
    output logic             w_last,
    input  logic             b_valid
);
    import cache_pkg::*;

    typedef enum logic [2:0] {bst_idle, bst_ar, bst_r, bst_aw, bst_w, bst_b} bst_t;

    bst_t  st_q;
    addr_t addr_q;
    way_t  way_q;
    beat_t r_beat_q;
    beat_t rd_beat_q;
    beat_t ld_beat_q;
    logic  rd_more_q;
    logic  rd_pend_q;
    logic  done_q;
    word_t hold_q;
    logic  hold_valid_q;
    logic  hold_last_q;
    logic  load;
    logic  issue_rd;

    // array word moves into the hold register once the bus slot frees up
    assign load     = rd_pend_q && (st_q == bst_w) && (!hold_valid_q || w_ready);
    assign issue_rd = (st_q == bst_aw || st_q == bst_w) && rd_more_q && (!rd_pend_q || load);

    always_ff @(posedge clk) begin
        if (rst) begin
            st_q         <= bst_idle;
            done_q       <= 1'b0;
            rd_more_q    <= 1'b0;
            rd_pend_q    <= 1'b0;
            hold_valid_q <= 1'b0;
            hold_last_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (st_q)
                bst_idle: begin
                    if (bu.start_read) begin
                        st_q <= bst_ar;
                    end else if (bu.start_write) begin
                        st_q      <= bst_aw;
                        rd_more_q <= 1'b1;
                    end
                end
                bst_ar: if (ar_ready) st_q <= bst_r;
                bst_r: begin
                    if (r_valid && r_last) begin
                        st_q   <= bst_idle;
                        done_q <= 1'b1;
                    end
                end
                bst_aw: if (aw_ready) st_q <= bst_w;
                bst_w: if (hold_valid_q && w_ready && hold_last_q) st_q <= bst_b;
                bst_b: begin
                    if (b_valid) begin
                        st_q   <= bst_idle;
                        done_q <= 1'b1;
                    end
                end
                default: st_q <= bst_idle;
            endcase
            if (issue_rd && rd_beat_q == '1) begin
                rd_more_q <= 1'b0;
            end
            if (issue_rd) begin
                rd_pend_q <= 1'b1;
            end else if (load) begin
                rd_pend_q <= 1'b0;
            end
            if (load) begin
                hold_valid_q <= 1'b1;
                hold_last_q  <= (ld_beat_q == '1);
            end else if (w_ready) begin
                hold_valid_q <= 1'b0;
                hold_last_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st_q == bst_idle && (bu.start_read || bu.start_write)) begin
            addr_q    <= bu.line_addr;
            way_q     <= bu.way;
            r_beat_q  <= '0;
            rd_beat_q <= '0;
            ld_beat_q <= '0;
        end
        if (st_q == bst_r && r_valid) begin
            r_beat_q <= r_beat_q + 1'b1;
        end
        if (issue_rd) begin
            rd_beat_q <= rd_beat_q + 1'b1;
        end
        if (load) begin
            hold_q    <= dp.rdata;
            ld_beat_q <= ld_beat_q + 1'b1;
        end
    end

    // refill writes every returned beat straight into the chosen way
    assign dp.way   = way_q;
    assign dp.index = addr_q[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign dp.beat  = (st_q == bst_r) ? r_beat_q : rd_beat_q;
    assign dp.rd_en = issue_rd;
    assign dp.wr_en = (st_q == bst_r) && r_valid;
    assign dp.strb  = '1;
    assign dp.wdata = r_data;

    assign ar_addr  = addr_q;
    assign ar_valid = (st_q == bst_ar);
    assign aw_addr  = addr_q;
    assign aw_valid = (st_q == bst_aw);
    assign w_data   = hold_q;
    assign w_valid  = hold_valid_q;
    assign w_last   = hold_last_q;
    assign bu.done  = done_q;

endmodule

//--- verilog/cache_ctrl.sv
// Cache controller with request register, miss FSM and response handshake
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t addr,
    input  logic             avalid,
    output logic             aready,
    input  cache_pkg::word_t wdata,
    input  cache_pkg::strb_t wstrb,
    output cache_pkg::word_t rdata,
    output logic             bvalid,
    input  logic             bready,
    output logic             hit,
    lookup_if.ctrl           lk,
    burst_if.ctrl            bu,
    data_port_if.client      dp
);
    import cache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    addr_t       addr_q;
    word_t       wdata_q;
    strb_t       wstrb_q;
    way_t        vict_way_q;
    logic        hit_q;

    addr_t  cur_addr;
    word_t  cur_wdata;
    strb_t  cur_strb;
    index_t cur_index;
    tag_t   cur_tag;
    beat_t  cur_beat;
    logic   accept;
    logic   is_wr;
    logic   do_access;

    assign aready = (state_q == st_lookup);
    assign accept = avalid && aready;

    // live request while idle, registered copy otherwise
    assign cur_addr  = (state_q == st_lookup) ? addr : addr_q;
    assign cur_wdata = (state_q == st_lookup) ? wdata : wdata_q;
    assign cur_strb  = (state_q == st_lookup) ? wstrb : wstrb_q;
    assign cur_index = cur_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign cur_tag   = cur_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign cur_beat  = cur_addr[`CACHE_OFFSET_W-1 -: $bits(beat_t)];
    assign is_wr     = |cur_strb;

    // replay always hits after the fill
    assign do_access = (state_q == st_lookup && accept && lk.hit) || (state_q == st_replay);

    assign lk.index     = cur_index;
    assign lk.tag       = cur_tag;
    assign lk.write_hit = do_access && is_wr;
    assign lk.fill_way  = vict_way_q;
    assign lk.clean_way = vict_way_q;

    assign dp.way   = lk.hit_way;
    assign dp.index = cur_index;
    assign dp.beat  = cur_beat;
    assign dp.rd_en = do_access && !is_wr;
    assign dp.wr_en = do_access && is_wr;
    assign dp.strb  = cur_strb;
    assign dp.wdata = cur_wdata;

    // writeback targets the victim line, refill the requested one
    assign bu.line_addr = bu.start_write ?
                          {lk.victim_tag, cur_index, {`CACHE_OFFSET_W{1'b0}}} :
                          {cur_tag, cur_index, {`CACHE_OFFSET_W{1'b0}}};
    assign bu.way = (state_q == st_lookup) ? lk.victim_way : vict_way_q;

    always_comb begin
        state_d        = state_q;
        bu.start_read  = 1'b0;
        bu.start_write = 1'b0;
        lk.clean       = 1'b0;
        lk.fill        = 1'b0;
        case (state_q)
            st_lookup: begin
                if (accept) begin
                    if (lk.hit) begin
                        state_d = st_respond;
                    end else if (lk.victim_dirty) begin
                        bu.start_write = 1'b1;
                        state_d        = st_writeback;
                    end else begin
                        bu.start_read = 1'b1;
                        state_d       = st_refill;
                    end
                end
            end
            st_writeback: begin
                if (bu.done) begin
                    lk.clean      = 1'b1;
                    bu.start_read = 1'b1;
                    state_d       = st_refill;
                end
            end
            st_refill: begin
                if (bu.done) begin
                    lk.fill = 1'b1;
                    state_d = st_replay;
                end
            end
            st_replay: state_d = st_respond;
            st_respond: begin
                if (bready) begin
                    state_d = st_lookup;
                end
            end
            default: state_d = st_lookup;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_lookup;
            hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                hit_q <= lk.hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
            if (!lk.hit) begin
                vict_way_q <= lk.victim_way;
            end
        end
    end

    assign bvalid = (state_q == st_respond);
    assign hit    = hit_q;
    assign rdata  = dp.rdata;

endmodule

//--- verilog/cache_top.sv
// Four-way write-back data cache top level with request and memory burst ports
`timescale 1ns/1ps

module cache_top (
    input  logic             clk,
    input  logic             rst,

    // request side
    input  cache_pkg::addr_t addr,
    input  logic             avalid,
    output logic             aready,
    input  cache_pkg::word_t wdata,
    input  cache_pkg::strb_t wstrb,
    output cache_pkg::word_t rdata,
    output logic             bvalid,
    input  logic             bready,
    output logic             hit,

    // memory side
    output cache_pkg::addr_t ar_addr,
    output logic             ar_valid,
    input  logic             ar_ready,
    input  cache_pkg::word_t r_data,
    input  logic             r_valid,
    input  logic             r_last,
    output cache_pkg::addr_t aw_addr,
    output logic             aw_valid,
    input  logic             aw_ready,
    output cache_pkg::word_t w_data,
    output logic             w_valid,
    input  logic             w_ready,
    output logic             w_last,
    input  logic             b_valid
);

    lookup_if    lk_if ();
    burst_if     bu_if ();
    data_port_if ctrl_dp ();
    data_port_if burst_dp ();

    cache_ctrl ctrl0 (
        .clk    (clk),
        .rst    (rst),
        .addr   (addr),
        .avalid (avalid),
        .aready (aready),
        .wdata  (wdata),
        .wstrb  (wstrb),
        .rdata  (rdata),
        .bvalid (bvalid),
        .bready (bready),
        .hit    (hit),
        .lk     (lk_if),
        .bu     (bu_if),
        .dp     (ctrl_dp)
    );

    tag_store tags0 (
        .clk (clk),
        .rst (rst),
        .lk  (lk_if)
    );

    data_store data0 (
        .clk        (clk),
        .ctrl_port  (ctrl_dp),
        .burst_port (burst_dp)
    );

    mem_burst burst0 (
        .clk      (clk),
        .rst      (rst),
        .bu       (bu_if),
        .dp       (burst_dp),
        .ar_addr  (ar_addr),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r_data   (r_data),
        .r_valid  (r_valid),
        .r_last   (r_last),
        .aw_addr  (aw_addr),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w_data   (w_data),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_last   (w_last),
        .b_valid  (b_valid)
    );

endmodule

//--- test/cache_chk.sv
// Handshake and payload stability assertions bound into the cache top level
`timescale 1ns/1ps

module cache_chk (
    input logic             clk,
    input logic             rst,
    input logic             avalid,
    input logic             aready,
    input logic             bvalid,
    input logic             bready,
    input logic             hit,
    input cache_pkg::word_t rdata,
    input logic             ar_valid,
    input logic             ar_ready,
    input cache_pkg::addr_t ar_addr,
    input logic             aw_valid,
    input logic             aw_ready,
    input cache_pkg::addr_t aw_addr,
    input logic             w_valid,
    input logic             w_ready,
    input cache_pkg::word_t w_data,
    input logic             w_last
);

    int err_count = 0;

    // response held with its payload until taken
    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(rdata) && $stable(hit))
        else begin
            $error("response dropped or changed before bready");
            err_count++;
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else begin
            $error("read address dropped or changed before ar_ready");
            err_count++;
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else begin
            $error("write address dropped or changed before aw_ready");
            err_count++;
        end

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_last))
        else begin
            $error("write beat dropped or changed before w_ready");
            err_count++;
        end

    a_wlast: assert property (@(posedge clk) disable iff (rst) w_last |-> w_valid)
        else begin
            $error("w_last raised without w_valid");
            err_count++;
        end

    // once accepted, aready stays low until the response is taken
    a_aready: assert property (@(posedge clk) disable iff (rst)
        (avalid && aready) || (!aready && !(bvalid && bready)) |=> !aready)
        else begin
            $error("aready high while a response is pending");
            err_count++;
        end

endmodule

bind cache_top cache_chk chk0 (
    .clk      (clk),
    .rst      (rst),
    .avalid   (avalid),
    .aready   (aready),
    .bvalid   (bvalid),
    .bready   (bready),
    .hit      (hit),
    .rdata    (rdata),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar_addr  (ar_addr),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw_addr  (aw_addr),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w_data   (w_data),
    .w_last   (w_last)
);

//--- test/cache_tb.sv
// Testbench for the write-back cache with memory model, shadow memory and tag model
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tb;
    import cache_pkg::*;

    localparam int n_directed  = 10;
    localparam int n_random    = 300;
    localparam int cycle_limit = (n_directed + n_random) * 200 + 500;

    typedef struct packed {
        logic  is_rd;
        logic  hit;
        logic  wb;
        word_t word;
        addr_t line;
        addr_t wb_line;
        int    ar_cnt;
        int    aw_cnt;
    } resp_t;

    logic  clk;
    logic  rst;
    addr_t addr;
    logic  avalid;
    logic  aready;
    word_t wdata;
    strb_t wstrb;
    word_t rdata;
    logic  bvalid;
    logic  bready;
    logic  hit;
    addr_t ar_addr;
    logic  ar_valid;
    logic  ar_ready;
    word_t r_data;
    logic  r_valid;
    logic  r_last;
    addr_t aw_addr;
    logic  aw_valid;
    logic  aw_ready;
    word_t w_data;
    logic  w_valid;
    logic  w_ready;
    logic  w_last;
    logic  b_valid;

    word_t mem_q [addr_t];
    word_t shadow_q [addr_t];
    tag_t  m_tag [`CACHE_SETS][`CACHE_WAYS];
    bit    m_valid [`CACHE_SETS][`CACHE_WAYS];
    bit    m_dirty [`CACHE_SETS][`CACHE_WAYS];
    int    m_ptr [`CACHE_SETS];
    resp_t exp_q [$];
    addr_t rd_addr;
    addr_t wr_addr;
    addr_t last_ar;
    addr_t last_aw;
    int    rd_left;
    int    rd_beat;
    int    wr_beat;
    int    b_wait;
    int    ar_count;
    int    aw_count;
    int    resp_count;
    int    cycles;
    bit    bp_on;

    cache_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // background memory contents tied to the whole address
    function automatic word_t fill_word(addr_t a);
        return {a ^ 32'h9e37_79b9, ~a};
    endfunction

    function automatic word_t mem_word(addr_t a);
        if (mem_q.exists(a)) begin
            return mem_q[a];
        end
        return fill_word(a);
    endfunction

    // expected word as seen by a correct cache
    function automatic word_t ref_word(addr_t a);
        if (shadow_q.exists(a)) begin
            return shadow_q[a];
        end
        return fill_word(a);
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t d, strb_t s);
        word_t r;
        r = old;
        for (int b = 0; b < `CACHE_STRB_W; b++) begin
            if (s[b]) begin
                r[8*b +: 8] = d[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic addr_t line_of(addr_t a);
        return {a[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
    endfunction

    function automatic addr_t make_addr(tag_t t, int set, int beat);
        return {t, index_t'(set), beat_t'(beat), 3'b000};
    endfunction

    function automatic logic ready_roll();
        if (!bp_on) begin
            return 1'b1;
        end
        return $urandom_range(0, 3) != 0;
    endfunction

    // tag model with fifo replacement per set
    task automatic model_access(input addr_t a, input bit is_wr, output logic e_hit,
                                output logic e_wb, output addr_t wb_line);
        int   idx;
        int   way;
        tag_t tg;
        idx     = a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
        tg      = a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        e_hit   = 1'b0;
        e_wb    = 1'b0;
        wb_line = '0;
        way     = 0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                e_hit = 1'b1;
                way   = w;
            end
        end
        if (!e_hit) begin
            way = m_ptr[idx];
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                e_wb    = 1'b1;
                wb_line = {m_tag[idx][way], index_t'(idx), {`CACHE_OFFSET_W{1'b0}}};
            end
            m_tag[idx][way]   = tg;
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
            m_ptr[idx]        = (m_ptr[idx] + 1) % `CACHE_WAYS;
        end
        if (is_wr) begin
            m_dirty[idx][way] = 1'b1;
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_req(input addr_t a, input word_t d, input strb_t s);
        resp_t e;
        while (!aready) begin
            @(negedge clk);
        end
        addr   = a;
        wdata  = d;
        wstrb  = s;
        avalid = 1'b1;
        model_access(a, |s, e.hit, e.wb, e.wb_line);
        e.is_rd  = ~|s;
        e.word   = ref_word(a);
        e.line   = line_of(a);
        e.ar_cnt = ar_count + (e.hit ? 0 : 1);
        e.aw_cnt = aw_count + (e.wb ? 1 : 0);
        exp_q.push_back(e);
        if (|s) begin
            shadow_q[a] = merge_bytes(ref_word(a), d, s);
        end
        @(negedge clk);
        avalid = 1'b0;
        wstrb  = '0;
        // a hit answers in the next cycle and a miss starts its burst then
        if (e.hit) begin
            check_val("bvalid", bvalid, 1'b1);
        end else if (e.wb) begin
            check_val("aw_valid", aw_valid, 1'b1);
        end else begin
            check_val("ar_valid", ar_valid, 1'b1);
        end
    endtask

    // memory model, one decision per falling edge
    initial begin : mem_model
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        r_last   = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                r_valid = 1'b0;
                r_last  = 1'b0;
                if (rd_left > 0 && ready_roll()) begin
                    r_valid = 1'b1;
                    r_data  = mem_word(rd_addr + 8 * rd_beat);
                    r_last  = (rd_left == 1);
                    rd_beat++;
                    rd_left--;
                end
                ar_ready = ready_roll();
                if (ar_valid && ar_ready) begin
                    rd_addr = ar_addr;
                    last_ar = ar_addr;
                    rd_beat = 0;
                    rd_left = `CACHE_BEATS;
                    ar_count++;
                end
                b_valid = 1'b0;
                if (b_wait > 0) begin
                    b_wait--;
                    b_valid = (b_wait == 0);
                end
                w_ready = ready_roll();
                if (w_valid && w_ready) begin
                    // written back data must carry every accepted write
                    check_val("w_data", w_data, ref_word(wr_addr + 8 * wr_beat));
                    check_val("w_last", w_last, wr_beat == `CACHE_BEATS - 1);
                    mem_q[wr_addr + 8 * wr_beat] = w_data;
                    wr_beat++;
                    if (w_last) begin
                        b_wait = $urandom_range(1, 3);
                    end
                end
                aw_ready = ready_roll();
                if (aw_valid && aw_ready) begin
                    wr_addr = aw_addr;
                    last_aw = aw_addr;
                    wr_beat = 0;
                    aw_count++;
                end
            end
        end
    end

    // response compare, drives bready
    initial begin : compare_proc
        resp_t e;
        bready = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                bready = ready_roll();
                if (bvalid && bready) begin
                    if (exp_q.size() == 0) begin
                        $display("response arrived with no request outstanding");
                        stop_run();
                    end else begin
                        e = exp_q.pop_front();
                        check_val("hit", hit, e.hit);
                        if (e.is_rd) begin
                            check_val("rdata", rdata, e.word);
                        end
                        check_val("ar_count", ar_count, e.ar_cnt);
                        check_val("aw_count", aw_count, e.aw_cnt);
                        if (!e.hit) begin
                            check_val("ar_addr", last_ar, e.line);
                        end
                        if (e.wb) begin
                            check_val("aw_addr", last_aw, e.wb_line);
                        end
                        resp_count++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (dut0.chk0.err_count != 0) begin
            $display("a handshake assertion in the bound checker failed");
            stop_run();
        end else if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    initial begin : stimulus
        int    rand_init;
        addr_t a;
        word_t d;
        strb_t s;
        rand_init  = $urandom(32'h013f4fdc);
        rst        = 1'b1;
        addr       = '0;
        avalid     = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        bp_on      = 1'b0;
        rd_left    = 0;
        rd_beat    = 0;
        wr_beat    = 0;
        b_wait     = 0;
        ar_count   = 0;
        aw_count   = 0;
        resp_count = 0;
        cycles     = 0;
        for (int i = 0; i < `CACHE_SETS; i++) begin
            m_ptr[i] = 0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_valid[i][w] = 1'b0;
                m_dirty[i][w] = 1'b0;
                m_tag[i][w]   = '0;
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // cold read, then the same word again as a hit
        a = make_addr(tag_t'(1), 2, 3);
        send_req(a, '0, '0);
        send_req(a, '0, '0);
        // partial write hit and readback
        send_req(a, 64'h1122_3344_5566_7788, 8'b0101_1010);
        send_req(a, '0, '0);
        // five tags in set 5, first line dirty when the fifth arrives
        send_req(make_addr(tag_t'(10), 5, 7), 64'hdead_beef_0bad_f00d, 8'hf0);
        for (int i = 11; i <= 14; i++) begin
            send_req(make_addr(tag_t'(i), 5, i), '0, '0);
        end
        send_req(make_addr(tag_t'(10), 5, 7), '0, '0);

        // random traffic over three sets under back-pressure
        bp_on = 1'b1;
        for (int n = 0; n < n_random; n++) begin
            a = make_addr(tag_t'($urandom_range(0, 5)), $urandom_range(0, 2),
                          $urandom_range(0, 15));
            d = {$urandom, $urandom};
            s = ($urandom_range(0, 1) == 1) ? strb_t'($urandom_range(1, 255)) : '0;
            repeat ($urandom_range(0, 2)) @(negedge clk);
            send_req(a, d, s);
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (dut0.chk0.err_count != 0) begin
            $display("a handshake assertion in the bound checker failed");
            stop_run();
        end else if (resp_count == n_directed + n_random) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("only %0d responses seen", resp_count);
            stop_run();
        end
    end

endmodule

//--- cache.f
+incdir+include
verilog/cache_pkg.sv
verilog/cache_ifs.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/mem_burst.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
test/cache_chk.sv
test/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  # synthesizable cache
  - include_dirs:
      - include
    files:
      - verilog/cache_pkg.sv
      - verilog/cache_ifs.sv
      - verilog/tag_store.sv
      - verilog/data_store.sv
      - verilog/mem_burst.sv
      - verilog/cache_ctrl.sv
      - verilog/cache_top.sv

  # simulation only
  - target: test
    include_dirs:
      - include
    files:
      - test/cache_chk.sv
      - test/cache_tb.sv
